// File: conv_pkg.sv
package conv_pkg;

  //////////////////////////////
  // buffer word geometry
  //////////////////////////////

  // index and address width
  localparam int addr_w = 16;

  // kernel, stride and padding fields
  localparam int pad_w = 4;

  // pixels per buffer word
  localparam logic [addr_w-1:0] pixels_in_row = 16'd32;

  //////////////////////////////
  // pixel controller pacing
  //////////////////////////////

  // register stages in the per-word address path
  localparam int row_pipe_stages = 2;

  // idle cycles after a word that is not the last of its row
  localparam int word_gap = 2;

  // slab index of a word that has no overlap word in front
  localparam logic [addr_w-1:0] no_slab = '1;

  //////////////////////////////
  // encodings
  //////////////////////////////

  // only unit and double stride are handled
  typedef enum logic [pad_w-1:0] {
    stride_1 = 4'd1,
    stride_2 = 4'd2
  } stride_t;

  // y loop over kernel rows and output rows
  typedef enum logic [1:0] {
    loop_idle,
    loop_run,
    loop_done
  } loop_state_t;

endpackage

// File: conv_layer_config.sv
module conv_layer_config
  import conv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [pad_w-1:0]  k_init,
  input  logic [pad_w-1:0]  s_init,
  input  logic [pad_w-1:0]  p_init,
  input  logic [addr_w-1:0] ix_init,
  input  logic [pad_w-1:0]  ix_in_2pow_init,
  input  logic [addr_w-1:0] poy_init,
  output logic [pad_w-1:0]  k,
  output stride_t           s,
  output logic [pad_w-1:0]  p,
  output logic [addr_w-1:0] ix,
  output logic [addr_w-1:0] ix_mask,
  output logic [addr_w-1:0] poy
);

  // log2 of the input line width
  logic [pad_w-1:0] ix_in_2pow;

  // geometry is sampled for as long as reset is held
  // and frozen for the whole run afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      k          <= k_init;
      s          <= stride_t'(s_init);
      p          <= p_init;
      ix         <= ix_init;
      ix_in_2pow <= ix_in_2pow_init;
      poy        <= poy_init;
    end
  end

  // low ix_in_2pow bits set, wraps a row end back into the line
  assign ix_mask = {addr_w{1'b1}} >> (addr_w - ix_in_2pow);

  // the span arithmetic downstream only knows stride 1 and 2
  a_stride_legal: assert property (@(posedge clk) disable iff (reset)
    s inside {stride_1, stride_2});

  // mask and width have to describe the same line
  a_ix_pow2: assert property (@(posedge clk) disable iff (reset)
    ix == (addr_w'(1) << ix_in_2pow));

endmodule

// File: conv_row_loop_controller.sv
module conv_row_loop_controller
  import conv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              conv_compute,
  input  logic              loop_adr1_add_end,
  input  logic              valid_adr,
  input  logic [pad_w-1:0]  k,
  input  logic [addr_w-1:0] poy,
  input  logic [addr_w-1:0] ix,
  output logic              loop_y_add_end,
  output logic [addr_w-1:0] row_base,
  output logic              busy,
  output logic              done
);

  loop_state_t       state;
  logic [addr_w-1:0] row_cnt;
  logic [addr_w-1:0] last_row;
  logic              row_done;

  // k kernel rows for each of the poy output rows
  assign last_row = k * poy - 1'b1;

  // a row closes on the accepted word that ends it
  assign row_done = valid_adr && loop_adr1_add_end;

  //////////////////////////////
  // y loop fsm
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= loop_idle;
      row_cnt  <= '0;
      row_base <= '0;
    end else begin
      case (state)
        loop_idle, loop_done: begin
          // a new tile may start in the done cycle already
          if (conv_compute) begin
            state    <= loop_run;
            row_cnt  <= '0;
            row_base <= '0;
          end else begin
            state <= loop_idle;
          end
        end
        loop_run: begin
          if (row_done) begin
            if (loop_y_add_end) begin
              state <= loop_done;
            end else begin
              row_cnt  <= row_cnt + 1'b1;
              // next input line of the buffer
              row_base <= row_base + ix;
            end
          end
        end
        default: state <= loop_idle;
      endcase
    end
  end

  // final row flag, pixel controller stops after its last word
  assign loop_y_add_end = (state == loop_run) && (row_cnt == last_row);

  assign busy = (state == loop_run);
  // one cycle after the closing word
  assign done = (state == loop_done);

  // the word loop never runs ahead of the y loop
  a_no_word_when_idle: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> state != loop_idle);

endmodule

// File: conv_pixel_controller.sv
module conv_pixel_controller
  import conv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [pad_w-1:0]  k,
  input  stride_t           s,
  input  logic [pad_w-1:0]  p,
  input  logic [addr_w-1:0] ix,
  input  logic [addr_w-1:0] ix_mask,
  input  logic [addr_w-1:0] tile_x_start,
  input  logic [addr_w-1:0] pox,
  input  logic              conv_compute,
  input  logic              loop_y_add_end,
  input  logic              ifx_stall,
  output logic [pad_w-1:0]  west_pad,
  output logic [pad_w-1:0]  slab_num,
  output logic [pad_w-1:0]  east_pad,
  output logic [addr_w-1:0] row_start_idx,
  output logic [addr_w-1:0] row_end_idx,
  output logic [addr_w-1:0] reg_start_idx,
  output logic [addr_w-1:0] reg_end_idx,
  output logic [addr_w-1:0] row_slab_start_idx,
  output logic              valid_adr,
  output logic              loop_adr1_add_end
);

  // low bits of a word offset
  localparam logic [addr_w-1:0] word_lo = pixels_in_row - 1'b1;

  // word loop
  logic              signal_adr1_add;
  logic [addr_w-1:0] adr1;
  logic [addr_w-1:0] adr1_next;
  logic [addr_w-1:0] reg_from;
  logic [pad_w-1:0]  row_length;
  logic [pad_w-1:0]  stall_cnt;
  logic              accept;
  logic              first_word;
  logic [addr_w-1:0] span_c;

  // tile terms
  logic [addr_w-1:0] start_fix_c;
  logic [addr_w-1:0] ix_end_c;

  // stage 1
  logic [addr_w-1:0] ix_end_s1;
  logic [addr_w-1:0] start_fix_s1;
  logic [addr_w-1:0] row_start_s1;
  logic [addr_w-1:0] row_end_idx_s1;
  logic [addr_w-1:0] slab_start_s1;
  logic [pad_w-1:0]  west_pad_s1;
  logic [pad_w-1:0]  slab_num_s1;

  // stage 2
  logic [addr_w-1:0] p_ix;
  logic [pad_w-1:0]  right_pad_c;
  logic [addr_w-1:0] east_edge_c;
  logic [addr_w-1:0] row_end_c;
  logic [addr_w-1:0] row_end_fix_c;
  logic [addr_w-1:0] word_last_c;
  logic [addr_w-1:0] reg_to_c;
  logic [addr_w-1:0] start_fix_s2;
  logic [addr_w-1:0] row_end_fix_s2;
  logic [addr_w-1:0] reg_to_s2;
  logic [pad_w-1:0]  right_pad_s2;

  assign first_word = (adr1 == '0);

  // first input column minus one and last needed column,
  // ix_start = (ox_start - 1) * s + 1
  always_comb begin
    if (s == stride_2) begin
      start_fix_c = (tile_x_start << 1) - 2'd2;
      ix_end_c    = (tile_x_start << 1) + (pox << 1) + k - 3'd4;
    end else begin
      start_fix_c = tile_x_start - 1'b1;
      ix_end_c    = tile_x_start + pox + k - 2'd2;
    end
  end

  //////////////////////////////
  // stage 1
  //////////////////////////////

  always_ff @(posedge clk) begin
    ix_end_s1      <= ix_end_c;
    start_fix_s1   <= start_fix_c;
    row_start_s1   <= adr1 + start_fix_c;
    row_end_idx_s1 <= adr1 + start_fix_c + word_lo;
    // overlap word sits one word left of the tile start
    slab_start_s1  <= (first_word && tile_x_start != 1 && p != '0) ?
                      adr1 + start_fix_c - pixels_in_row : no_slab;
    west_pad_s1    <= (first_word && tile_x_start == 1) ? p : '0;
    slab_num_s1    <= (first_word && tile_x_start != 1) ? p : '0;
  end

  //////////////////////////////
  // stage 2
  //////////////////////////////

  // padding past the right image border
  assign p_ix        = ix + p;
  assign right_pad_c = (ix_end_s1 > p_ix) ? pad_w'(ix_end_s1 - p_ix) : '0;
  assign east_edge_c = ix_end_s1 - right_pad_c - p;
  assign row_end_c   = east_edge_c - 1'b1;

  // round the row end up to the last pixel of its word, inside the line
  assign row_end_fix_c = ((east_edge_c & word_lo) == '0) ?
                         (east_edge_c - 1'b1) & ix_mask :
                         ((east_edge_c & ~word_lo) + word_lo) & ix_mask;

  // a short last word only fills up to the row end
  assign word_last_c = row_start_s1 + word_lo;
  assign reg_to_c    = (word_last_c > row_end_c) ? reg_from + row_end_c - row_start_s1 :
                       reg_from + word_lo;

  always_ff @(posedge clk) begin
    row_start_idx      <= row_start_s1;
    row_end_idx        <= row_end_idx_s1;
    row_slab_start_idx <= slab_start_s1;
    west_pad           <= west_pad_s1;
    slab_num           <= slab_num_s1;
    start_fix_s2       <= start_fix_s1;
    right_pad_s2       <= right_pad_c;
    row_end_fix_s2     <= row_end_fix_c;
    reg_to_s2          <= reg_to_c;
  end

  //////////////////////////////
  // word loop
  //////////////////////////////

  assign adr1_next = adr1 + pixels_in_row;
  assign span_c    = row_end_fix_s2 - start_fix_s2;

  assign accept            = signal_adr1_add && (stall_cnt == '0) && !ifx_stall;
  assign loop_adr1_add_end = accept && (adr1_next > span_c);
  assign valid_adr         = accept;

  assign reg_start_idx = reg_from;
  // right padding is charged to the last word only
  assign east_pad      = loop_adr1_add_end ? right_pad_s2 : '0;
  assign reg_end_idx   = reg_to_s2 + east_pad;

  always_ff @(posedge clk) begin
    if (reset) begin
      signal_adr1_add <= 1'b0;
    end else if (conv_compute) begin
      signal_adr1_add <= 1'b1;
    end else if (loop_adr1_add_end && loop_y_add_end) begin
      signal_adr1_add <= 1'b0;
    end
  end

  // slot ranges chain from p+1 within a row
  always_ff @(posedge clk) begin
    if (reset) begin
      adr1     <= '0;
      reg_from <= '0;
    end else if (conv_compute || loop_adr1_add_end) begin
      adr1     <= '0;
      reg_from <= p + 1'b1;
    end else if (accept) begin
      adr1     <= adr1_next;
      reg_from <= reg_to_s2 + 1'b1;
    end
  end

  // words issued so far in this row
  always_ff @(posedge clk) begin
    if (reset) begin
      row_length <= '0;
    end else if (conv_compute || loop_adr1_add_end) begin
      row_length <= 4'd1;
    end else if (accept) begin
      row_length <= row_length + 1'b1;
    end
  end

  // gap counter, the pipeline is primed after start,
  // row regs need the long gap on short rows
  always_ff @(posedge clk) begin
    if (reset) begin
      stall_cnt <= '0;
    end else if (conv_compute) begin
      stall_cnt <= pad_w'(row_pipe_stages);
    end else if (accept) begin
      if (loop_adr1_add_end && loop_y_add_end) begin
        stall_cnt <= '0;
      end else if (loop_adr1_add_end && (int'(k) - int'(row_length) > word_gap + 2)) begin
        stall_cnt <= k - row_length - pad_w'(word_gap + 1);
      end else begin
        stall_cnt <= pad_w'(word_gap);
      end
    end else if (stall_cnt != '0) begin
      stall_cnt <= stall_cnt - 1'b1;
    end
  end

  // border padding only on the closing word, and that word reaches the line end
  a_east_pad_last: assert property (@(posedge clk) disable iff (reset)
    (east_pad != '0) |-> loop_adr1_add_end && (row_start_idx + word_lo >= ix - 1'b1));

  // stage 2 values need word_gap cycles to follow adr1
  a_word_spacing: assert property (@(posedge clk) disable iff (reset)
    valid_adr |=> !valid_adr [*word_gap]);

endmodule

// File: ifmap_row_fetch.sv
module ifmap_row_fetch
  import conv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              valid_adr,
  input  logic [addr_w-1:0] row_start_idx,
  input  logic [addr_w-1:0] row_slab_start_idx,
  input  logic [pad_w-1:0]  slab_num,
  input  logic [addr_w-1:0] row_base,
  input  logic              buf_ready,
  output logic              buf_rd_en,
  output logic [addr_w-1:0] buf_rd_addr,
  output logic              ifx_stall
);

  logic              word_pend;
  logic              slab_pend;
  logic [addr_w-1:0] word_addr;
  logic [addr_w-1:0] slab_addr;
  logic              need_slab;
  logic              issue;

  // overlap word only in front of the first word of a row
  assign need_slab = (slab_num != '0) && (row_slab_start_idx != no_slab);

  // a read leaves when the buffer takes it
  assign issue = buf_rd_en && buf_ready;

  //////////////////////////////
  // request register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      word_pend <= 1'b0;
      slab_pend <= 1'b0;
    end else if (valid_adr) begin
      word_pend <= 1'b1;
      slab_pend <= need_slab;
    end else if (issue) begin
      // slab goes out first, then the word itself
      if (slab_pend) begin
        slab_pend <= 1'b0;
      end else begin
        word_pend <= 1'b0;
      end
    end
  end

  // line offset plus pixel index
  always_ff @(posedge clk) begin
    if (valid_adr) begin
      word_addr <= row_base + row_start_idx;
      slab_addr <= row_base + row_slab_start_idx;
    end
  end

  assign buf_rd_en   = slab_pend || word_pend;
  assign buf_rd_addr = slab_pend ? slab_addr : word_addr;

  // hold the word loop until the queue drains
  assign ifx_stall = slab_pend || word_pend || !buf_ready;

  // a read waiting on the buffer keeps its address
  a_addr_hold: assert property (@(posedge clk) disable iff (reset)
    buf_rd_en && !buf_ready |=> buf_rd_en && $stable(buf_rd_addr));

endmodule

// File: conv_input_fetch_top.sv
module conv_input_fetch_top
  import conv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [pad_w-1:0]  k_init,
  input  logic [pad_w-1:0]  s_init,
  input  logic [pad_w-1:0]  p_init,
  input  logic [addr_w-1:0] ix_init,
  input  logic [pad_w-1:0]  ix_in_2pow_init,
  input  logic [addr_w-1:0] poy_init,
  input  logic [addr_w-1:0] tile_x_start,
  input  logic [addr_w-1:0] pox,
  input  logic              conv_compute,
  input  logic              buf_ready,
  output logic              buf_rd_en,
  output logic [addr_w-1:0] buf_rd_addr,
  output logic              valid_adr,
  output logic [pad_w-1:0]  west_pad,
  output logic [pad_w-1:0]  east_pad,
  output logic [addr_w-1:0] reg_start_idx,
  output logic [addr_w-1:0] reg_end_idx,
  output logic              loop_adr1_add_end,
  output logic              busy,
  output logic              done
);

  // layer geometry
  logic [pad_w-1:0]  k;
  stride_t           s;
  logic [pad_w-1:0]  p;
  logic [addr_w-1:0] ix;
  logic [addr_w-1:0] ix_mask;
  logic [addr_w-1:0] poy;

  // y loop to word loop and fetch
  logic              loop_y_add_end;
  logic [addr_w-1:0] row_base;

  // word loop to fetch stage
  logic              ifx_stall;
  logic [pad_w-1:0]  slab_num;
  logic [addr_w-1:0] row_start_idx;
  logic [addr_w-1:0] row_slab_start_idx;

  conv_layer_config u_config (.*);

  conv_row_loop_controller u_row_loop (.*);

  // the row end index is for the row registers, not the buffer
  conv_pixel_controller u_pixel (
    .row_end_idx (),
    .*
  );

  ifmap_row_fetch u_fetch (.*);

endmodule

// File: conv_input_fetch_tb.sv
module conv_input_fetch_tb
  import conv_pkg::*;
();

  // DUT ports
  logic              clk;
  logic              reset;
  logic [pad_w-1:0]  k_init;
  logic [pad_w-1:0]  s_init;
  logic [pad_w-1:0]  p_init;
  logic [addr_w-1:0] ix_init;
  logic [pad_w-1:0]  ix_in_2pow_init;
  logic [addr_w-1:0] poy_init;
  logic [addr_w-1:0] tile_x_start;
  logic [addr_w-1:0] pox;
  logic              conv_compute;
  logic              buf_ready;
  logic              buf_rd_en;
  logic [addr_w-1:0] buf_rd_addr;
  logic              valid_adr;
  logic [pad_w-1:0]  west_pad;
  logic [pad_w-1:0]  east_pad;
  logic [addr_w-1:0] reg_start_idx;
  logic [addr_w-1:0] reg_end_idx;
  logic              loop_adr1_add_end;
  logic              busy;
  logic              done;

  // layer and tile under test
  int cfg_k = 3;
  int cfg_s = 1;
  int cfg_p = 1;
  int cfg_ix = 128;
  int cfg_poy = 2;
  int cfg_t = 1;
  int cfg_pox = 1;

  // expected row shape and expected values of the next word
  int px;
  int n_rows;
  int start_col;
  int pad_end;
  int east_col;
  int exp_east;
  int row_end;
  int exp_words;
  int w_row_start;
  int w_fill;
  int w_east;
  int w_west;
  int w_reg_start;
  logic w_last;

  // scoreboard state
  int                m_word;
  int                m_row;
  logic [addr_w-1:0] m_prev_end;
  logic              m_slab_pend;
  logic              m_word_pend;
  logic [addr_w-1:0] m_slab_addr;
  logic [addr_w-1:0] m_word_addr;
  int                word_cnt = 0;
  int                done_cnt = 0;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  conv_input_fetch_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // reference rules
  //////////////////////////////

  always_comb begin
    px          = int'(pixels_in_row);
    n_rows      = cfg_k * cfg_poy;
    // first input column of the tile, 0-based
    start_col   = (cfg_t - 1) * cfg_s;
    // last padded column the kernel touches, 1-based
    pad_end     = (cfg_t + cfg_pox - 2) * cfg_s + cfg_k;
    east_col    = (pad_end - cfg_p < cfg_ix) ? pad_end - cfg_p : cfg_ix;
    exp_east    = (pad_end > cfg_ix + cfg_p) ? pad_end - cfg_ix - cfg_p : 0;
    // last pixel of the word holding the row end, kept inside the line
    row_end     = ((east_col - 1) | (px - 1)) & (cfg_ix - 1);
    exp_words   = (row_end + 1 - start_col) / px;
    w_row_start = start_col + px * m_word;
    w_last      = (m_word == exp_words - 1);
    // a short last word fills only up to the last real pixel
    w_fill      = (east_col - 1 - w_row_start < px - 1) ? east_col - 1 - w_row_start : px - 1;
    w_east      = w_last ? exp_east : 0;
    w_west      = (m_word == 0 && cfg_t == 1) ? cfg_p : 0;
    w_reg_start = (m_word == 0) ? cfg_p + 1 : int'(m_prev_end) + 1;
  end

  // word position, row position and the reads the buffer should see
  always @(posedge clk) begin
    if (reset) begin
      m_word      <= 0;
      m_row       <= 0;
      m_prev_end  <= '0;
      m_slab_pend <= 1'b0;
      m_word_pend <= 1'b0;
    end else begin
      if (conv_compute) begin
        m_word <= 0;
        m_row  <= 0;
      end
      if (valid_adr) begin
        word_cnt    <= word_cnt + 1;
        m_prev_end  <= reg_end_idx;
        m_word_pend <= 1'b1;
        // overlap word only ahead of the first word of an inner tile
        m_slab_pend <= (m_word == 0 && cfg_t != 1 && cfg_p != 0);
        m_word_addr <= addr_w'(m_row * cfg_ix + w_row_start);
        m_slab_addr <= addr_w'(m_row * cfg_ix + start_col - px);
        if (loop_adr1_add_end) begin
          m_word <= 0;
          m_row  <= m_row + 1;
        end else begin
          m_word <= m_word + 1;
        end
      end else if (buf_ready && m_slab_pend) begin
        m_slab_pend <= 1'b0;
      end else if (buf_ready && m_word_pend) begin
        m_word_pend <= 1'b0;
      end
      if (done) begin
        done_cnt <= done_cnt + 1;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_gap: assert property (@(posedge clk) disable iff (reset)
    valid_adr |=> !valid_adr [*word_gap])
    else report_failure("two words accepted less than three cycles apart");

  a_row_len: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> loop_adr1_add_end == w_last)
    else report_mismatch($sformatf("row end flag on word %0d, row has %0d words",
                                   m_word, exp_words));

  a_reg_start: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> int'(reg_start_idx) == w_reg_start)
    else report_mismatch($sformatf("reg_start_idx %0d, expected %0d",
                                   $sampled(reg_start_idx), w_reg_start));

  a_reg_end: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> int'(reg_end_idx) == w_reg_start + w_fill + w_east)
    else report_mismatch($sformatf("reg_end_idx %0d, expected %0d", $sampled(reg_end_idx),
                                   w_reg_start + w_fill + w_east));

  a_west: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> int'(west_pad) == w_west)
    else report_mismatch($sformatf("west_pad %0d, expected %0d", $sampled(west_pad), w_west));

  a_east: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> int'(east_pad) == w_east)
    else report_mismatch($sformatf("east_pad %0d, expected %0d", $sampled(east_pad), w_east));

  a_east_last: assert property (@(posedge clk) disable iff (reset)
    east_pad != '0 |-> valid_adr && loop_adr1_add_end)
    else report_failure("east padding outside the last word of a row");

  a_rd_en: assert property (@(posedge clk) disable iff (reset)
    buf_rd_en == (m_slab_pend || m_word_pend))
    else report_mismatch($sformatf("buf_rd_en %0b, expected %0b",
                                   $sampled(buf_rd_en), m_slab_pend || m_word_pend));

  a_rd_addr: assert property (@(posedge clk) disable iff (reset)
    buf_rd_en |-> buf_rd_addr == (m_slab_pend ? m_slab_addr : m_word_addr))
    else report_mismatch($sformatf("buf_rd_addr %0d, expected %0d", $sampled(buf_rd_addr),
                                   m_slab_pend ? m_slab_addr : m_word_addr));

  // back-pressure freezes the word loop and the pending read
  a_stall: assert property (@(posedge clk) disable iff (reset)
    !buf_ready |-> !valid_adr)
    else report_failure("word accepted while the buffer was not ready");

  a_hold: assert property (@(posedge clk) disable iff (reset)
    buf_rd_en && !buf_ready |=> buf_rd_en && $stable(buf_rd_addr))
    else report_failure("pending read dropped or moved while the buffer was not ready");

  a_busy: assert property (@(posedge clk) disable iff (reset)
    valid_adr |-> busy)
    else report_failure("word accepted outside a running tile");

  a_done_when: assert property (@(posedge clk) disable iff (reset)
    valid_adr && loop_adr1_add_end && m_row == n_rows - 1 |=> done && !busy)
    else report_failure("done missing after the closing word of the tile");

  a_done_rows: assert property (@(posedge clk) disable iff (reset)
    done |-> m_row == n_rows)
    else report_mismatch($sformatf("done after %0d rows, expected %0d", m_row, n_rows));

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else report_failure("done held for more than one cycle");

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at time %0t: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  // every word waits out the gap and up to two reads
  function automatic int worst_tile_cycles(input int words, input int rows);
    return rows * words * (word_gap + 3) + 16;
  endfunction

  // geometry is only taken while reset is high
  task automatic apply_reset(input int k, input int s, input int p);
    @(posedge clk);
    reset   <= 1'b1;
    k_init  <= pad_w'(k);
    s_init  <= pad_w'(s);
    p_init  <= pad_w'(p);
    cfg_k   <= k;
    cfg_s   <= s;
    cfg_p   <= p;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_tile(input string name, input int t, input int width);
    int err0;
    int words0;
    int done0;
    int limit;
    int cycles;
    err0   = errors;
    words0 = word_cnt;
    done0  = done_cnt;
    @(posedge clk);
    cfg_t        <= t;
    cfg_pox      <= width;
    tile_x_start <= addr_w'(t);
    pox          <= addr_w'(width);
    conv_compute <= 1'b1;
    @(posedge clk);
    conv_compute <= 1'b0;
    @(negedge clk);
    limit  = 4 * worst_tile_cycles(exp_words, n_rows);
    cycles = 0;
    while (!done && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      report_failure($sformatf("no done within %0d cycles", limit));
    end
    // quiet time, nothing may follow the done pulse
    repeat (8) @(negedge clk);
    assert (done_cnt - done0 == 1)
      else report_failure($sformatf("done pulsed %0d times", done_cnt - done0));
    assert (word_cnt - words0 == exp_words * n_rows)
      else report_mismatch($sformatf("%0d words in the tile, expected %0d",
                                     word_cnt - words0, exp_words * n_rows));
    assert (!busy)
      else report_failure("busy still high after done");
    tests_run++;
    if (errors == err0) begin
      $display("test %0d (%s): ok, %0d words", tests_run, name, word_cnt - words0);
    end else begin
      tests_failed++;
      $display("test %0d (%s): FAILED with %0d errors", tests_run, name, errors - err0);
    end
  endtask

  //////////////////////////////
  // buffer model
  //////////////////////////////

  initial begin
    void'($urandom(32'h9e5a));
    buf_ready <= 1'b1;
    forever begin
      @(posedge clk);
      // ready about three cycles in four
      buf_ready <= reset ? 1'b1 : ($urandom % 4 != 0);
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    reset           <= 1'b1;
    conv_compute    <= 1'b0;
    k_init          <= pad_w'(cfg_k);
    s_init          <= pad_w'(cfg_s);
    p_init          <= pad_w'(cfg_p);
    ix_init         <= addr_w'(cfg_ix);
    ix_in_2pow_init <= pad_w'($clog2(cfg_ix));
    poy_init        <= addr_w'(cfg_poy);
    tile_x_start    <= addr_w'(1);
    pox             <= addr_w'(1);
    apply_reset(3, 1, 1);
    run_tile("stride 1, tile at column 1", 1, 40);
    // reaches the right border, one column of east padding
    run_tile("stride 1, tile at column 33", 33, 96);
    apply_reset(3, 2, 1);
    run_tile("stride 2, tile at column 1", 1, 20);
    run_tile("stride 2, tile at column 33", 33, 32);
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // two resets plus four tiles of at most three words per row
  initial begin
    int limit;
    limit = 4 * (2 * 17 + 4 * worst_tile_cycles(3, 3 * cfg_poy));
    repeat (limit) @(posedge clk);
    $display("run stopped by the watchdog after %0d cycles", limit);
    $display("Something failed");
    $finish;
  end

endmodule

// File: build.f
conv_pkg.sv
conv_layer_config.sv
conv_row_loop_controller.sv
conv_pixel_controller.sv
ifmap_row_fetch.sv
conv_input_fetch_top.sv
conv_input_fetch_tb.sv
